/* prefetch_pkg.sv */
`default_nettype none

package prefetch_pkg;

   // ----------------------------------------
   // Widths shared by both banks and stages.
   // ----------------------------------------

   // Sample word width.
   localparam int DATA_W = 32;
   // Bank address width, so each bank holds 2^ADR_W words.
   localparam int ADR_W = 10;

   // ----------------------------------------
   // Bus structs.
   // ----------------------------------------

   // Master to slave request.
   // A strobe counts only while cyc is also high.
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      // Bulk sequential transfer, more strobes follow.
      logic              bst;
      logic [ADR_W-1:0]  adr;
      logic [DATA_W-1:0] dat;
   } bus_req_t;

   // Slave to master response.
   // Ack follows the strobe by exactly one cycle.
   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat;
   } bus_rsp_t;

   // Word handed from the fetch stage to the store stage.
   typedef struct packed {
      logic              valid;
      logic              last;
      logic [DATA_W-1:0] data;
   } fetch_word_t;

   // Fetch FSM states.
   typedef enum logic [1:0] {
      FETCH_IDLE  = 2'd0,
      FETCH_BURST = 2'd1,
      FETCH_DRAIN = 2'd2
   } fetch_state_e;

endpackage

`default_nettype wire

/* src_bank.sv */
`default_nettype none

module src_bank (
   input  wire                              clk_i,
   // Read bus from the fetch stage.
   input  wire prefetch_pkg::bus_req_t      a_req_i,
   output prefetch_pkg::bus_rsp_t           a_rsp_o,
   // Host load port.
   input  wire                              load_we_i,
   input  wire [prefetch_pkg::ADR_W-1:0]    load_adr_i,
   input  wire [prefetch_pkg::DATA_W-1:0]   load_dat_i
);

   import prefetch_pkg::*;

   // Sample storage.
   logic [DATA_W-1:0] mem [2**ADR_W];

   // Registered response.
   logic              ack_q;
   logic [DATA_W-1:0] rdat_q;

   // Bus strobe qualified by the cycle.
   logic              strobe;

   assign strobe = a_req_i.cyc && a_req_i.stb;

   // ----------------------------------------
   // Host load and bus read.
   // ----------------------------------------

   // The host only writes here; the bus side only reads.
   always_ff @(posedge clk_i) begin
      if (load_we_i) begin
         mem[load_adr_i] <= load_dat_i;
      end
   end

   // Ack every strobe one cycle later, no wait states.
   always_ff @(posedge clk_i) begin
      ack_q <= strobe;
   end

   // Read data travels with its ack.
   always_ff @(posedge clk_i) begin
      if (strobe && !a_req_i.we) begin
         rdat_q <= mem[a_req_i.adr];
      end
   end

   assign a_rsp_o = '{ack: ack_q, dat: rdat_q};

   // Host loads must not overlap a prefetch burst.
   a_no_load_in_cycle: assert property (
      @(posedge clk_i) load_we_i |-> !a_req_i.cyc
   );

endmodule

`default_nettype wire

/* fetch_stage.sv */
`default_nettype none

module fetch_stage #(
   parameter int COUNT = 575,
   parameter int BSIZE = 23,
   parameter int BBITS = 5
) (
   input  wire                              clk_i,
   input  wire                              rst_i,
   input  wire                              begin_i,
   // Port A read master.
   output prefetch_pkg::bus_req_t           a_req_o,
   input  wire prefetch_pkg::bus_rsp_t      a_rsp_i,
   // Words to the store stage.
   output prefetch_pkg::fetch_word_t        fwd_o,
   output logic                             busy_o
);

   import prefetch_pkg::*;

   // Strobe counter width, at least one bit.
   localparam int CNT_W = (COUNT > 0) ? $clog2(COUNT + 1) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(COUNT);
   // Jump from the last valid word to the start of the next block.
   localparam logic [ADR_W-1:0] BSTEP = ADR_W'((1 << BBITS) - BSIZE);

   fetch_state_e      state_q;
   logic              cyc_q;
   logic              stb_q;
   logic [ADR_W-1:0]  adr_q;
   logic [ADR_W-1:0]  adr_next;
   logic [CNT_W-1:0]  cnt_q;
   logic              at_last;
   logic              start;
   logic              busy_q;

   // Strobe tracking for the response side.
   logic              pend_q;
   logic              pend_last_q;

   // Forwarded word.
   logic              fwd_vld_q;
   logic              fwd_last_q;
   logic [DATA_W-1:0] fwd_dat_q;

   assign at_last = (cnt_q == CNT_LAST);
   assign start   = (state_q == FETCH_IDLE) && begin_i && !busy_q;

   // Skip the unused tail of each block.
   assign adr_next = (adr_q[BBITS-1:0] == BBITS'(BSIZE)) ? adr_q + BSTEP
                                                         : adr_q + 1'b1;

   // ----------------------------------------
   // Fetch FSM.
   // ----------------------------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= FETCH_IDLE;
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
      end else begin
         case (state_q)
            FETCH_IDLE: begin
               // Begin is ignored while the previous run drains.
               if (start) begin
                  cyc_q   <= 1'b1;
                  stb_q   <= 1'b1;
                  state_q <= FETCH_BURST;
               end
            end
            FETCH_BURST: begin
               // One strobe per cycle until the final word is issued.
               if (at_last) begin
                  stb_q   <= 1'b0;
                  state_q <= FETCH_DRAIN;
               end
            end
            FETCH_DRAIN: begin
               if (a_rsp_i.ack) begin
                  cyc_q   <= 1'b0;
                  state_q <= FETCH_IDLE;
               end
            end
            default: state_q <= FETCH_IDLE;
         endcase
      end
   end

   // Address and count restart on every accepted begin.
   always_ff @(posedge clk_i) begin
      if (rst_i || start) begin
         adr_q <= '0;
         cnt_q <= '0;
      end else if (stb_q && !at_last) begin
         adr_q <= adr_next;
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign a_req_o = '{cyc: cyc_q,
                      stb: stb_q,
                      we:  1'b0,
                      bst: stb_q && !at_last,
                      adr: adr_q,
                      dat: '0};

   // ----------------------------------------
   // Response side.
   // ----------------------------------------

   // Remember which strobe the next ack answers.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pend_q      <= 1'b0;
         pend_last_q <= 1'b0;
         fwd_vld_q   <= 1'b0;
      end else begin
         pend_q      <= cyc_q && stb_q;
         pend_last_q <= cyc_q && stb_q && at_last;
         fwd_vld_q   <= a_rsp_i.ack;
      end
   end

   // Payload of each acked word.
   always_ff @(posedge clk_i) begin
      if (a_rsp_i.ack) begin
         fwd_dat_q  <= a_rsp_i.dat;
         fwd_last_q <= pend_last_q;
      end
   end

   assign fwd_o = '{valid: fwd_vld_q, last: fwd_last_q, data: fwd_dat_q};

   // Busy until the last word has been handed over.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q <= 1'b0;
      end else if (start) begin
         busy_q <= 1'b1;
      end else if (fwd_vld_q && fwd_last_q) begin
         busy_q <= 1'b0;
      end
   end

   assign busy_o = busy_q;

   // ----------------------------------------
   // Checks.
   // ----------------------------------------

   a_read_only: assert property (
      @(posedge clk_i) disable iff (rst_i) a_req_o.cyc |-> !a_req_o.we
   );

   a_adr_in_block: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (a_req_o.cyc && a_req_o.stb) |-> (a_req_o.adr[BBITS-1:0] <= BBITS'(BSIZE))
   );

   // The source bank must answer only real strobes.
   a_ack_has_strobe: assert property (
      @(posedge clk_i) disable iff (rst_i) a_rsp_i.ack |-> pend_q
   );

endmodule

`default_nettype wire

/* store_stage.sv */
`default_nettype none

module store_stage (
   input  wire                              clk_i,
   input  wire                              rst_i,
   // Words from the fetch stage.
   input  wire prefetch_pkg::fetch_word_t   fwd_i,
   // Port B write master.
   output prefetch_pkg::bus_req_t           b_req_o,
   input  wire prefetch_pkg::bus_rsp_t      b_rsp_i,
   output logic                             done_o
);

   import prefetch_pkg::*;

   // Destination address of the next write.
   logic [ADR_W-1:0] adr_q;
   // The write in flight carries the last word.
   logic             pend_last_q;

   // ----------------------------------------
   // Write strobes.
   // ----------------------------------------

   // One write per valid word, straight from the handoff register.
   assign b_req_o = '{cyc: fwd_i.valid,
                      stb: fwd_i.valid,
                      we:  fwd_i.valid,
                      bst: fwd_i.valid && !fwd_i.last,
                      adr: adr_q,
                      dat: fwd_i.data};

   // Sequential addresses, back to zero after the last word.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         adr_q <= '0;
      end else if (fwd_i.valid) begin
         if (fwd_i.last) begin
            adr_q <= '0;
         end else begin
            adr_q <= adr_q + 1'b1;
         end
      end
   end

   // ----------------------------------------
   // Completion.
   // ----------------------------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pend_last_q <= 1'b0;
      end else begin
         pend_last_q <= fwd_i.valid && fwd_i.last;
      end
   end

   // Done rides on the ack of the last write.
   assign done_o = pend_last_q && b_rsp_i.ack;

   // No back-pressure, so every write is acked next cycle.
   a_write_acked: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (b_req_o.cyc && b_req_o.stb) |=> b_rsp_i.ack
   );

endmodule

`default_nettype wire

/* dst_bank.sv */
`default_nettype none

module dst_bank (
   input  wire                              clk_i,
   // Write bus from the store stage.
   input  wire prefetch_pkg::bus_req_t      b_req_i,
   output prefetch_pkg::bus_rsp_t           b_rsp_o,
   // Host read-back port.
   input  wire [prefetch_pkg::ADR_W-1:0]    rd_adr_i,
   output logic [prefetch_pkg::DATA_W-1:0]  rd_dat_o
);

   import prefetch_pkg::*;

   logic [DATA_W-1:0] mem [2**ADR_W];

   logic              strobe;
   logic              ack_q;
   logic [DATA_W-1:0] rd_dat_q;

   assign strobe = b_req_i.cyc && b_req_i.stb;

   // ----------------------------------------
   // Bus side.
   // ----------------------------------------

   // Writes land in the strobe cycle.
   always_ff @(posedge clk_i) begin
      if (strobe && b_req_i.we) begin
         mem[b_req_i.adr] <= b_req_i.dat;
      end
   end

   // Ack every strobe one cycle later.
   always_ff @(posedge clk_i) begin
      ack_q <= strobe;
   end

   // Write-only slave, so the response carries no data.
   assign b_rsp_o = '{ack: ack_q, dat: '0};

   // Host read-back, one cycle of latency.
   always_ff @(posedge clk_i) begin
      rd_dat_q <= mem[rd_adr_i];
   end

   assign rd_dat_o = rd_dat_q;

endmodule

`default_nettype wire

/* prefetch_top.sv */
`default_nettype none

module prefetch_top #(
   // Words to move, minus one.
   parameter int COUNT = 575,
   // Index of the last valid word in a block.
   parameter int BSIZE = 23,
   // Log2 of the block stride.
   parameter int BBITS = 5
) (
   input  wire                              clk_i,
   input  wire                              rst_i,
   input  wire                              begin_i,
   // Source load port.
   input  wire                              load_we_i,
   input  wire [prefetch_pkg::ADR_W-1:0]    load_adr_i,
   input  wire [prefetch_pkg::DATA_W-1:0]   load_dat_i,
   // Destination read-back port.
   input  wire [prefetch_pkg::ADR_W-1:0]    rd_adr_i,
   output logic [prefetch_pkg::DATA_W-1:0]  rd_dat_o,
   // Status.
   output logic                             busy_o,
   output logic                             done_o
);

   import prefetch_pkg::*;

   // Port A, fetch stage to source bank.
   bus_req_t    a_req;
   bus_rsp_t    a_rsp;
   // Handoff between the stages.
   fetch_word_t fwd;
   // Port B, store stage to destination bank.
   bus_req_t    b_req;
   bus_rsp_t    b_rsp;

   // ----------------------------------------
   // Source side.
   // ----------------------------------------

   src_bank u_src_bank (
      .clk_i      (clk_i),
      .a_req_i    (a_req),
      .a_rsp_o    (a_rsp),
      .load_we_i  (load_we_i),
      .load_adr_i (load_adr_i),
      .load_dat_i (load_dat_i)
   );

   fetch_stage #(
      .COUNT (COUNT),
      .BSIZE (BSIZE),
      .BBITS (BBITS)
   ) u_fetch_stage (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .begin_i (begin_i),
      .a_req_o (a_req),
      .a_rsp_i (a_rsp),
      .fwd_o   (fwd),
      .busy_o  (busy_o)
   );

   // ----------------------------------------
   // Destination side.
   // ----------------------------------------

   store_stage u_store_stage (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .fwd_i   (fwd),
      .b_req_o (b_req),
      .b_rsp_i (b_rsp),
      .done_o  (done_o)
   );

   dst_bank u_dst_bank (
      .clk_i    (clk_i),
      .b_req_i  (b_req),
      .b_rsp_o  (b_rsp),
      .rd_adr_i (rd_adr_i),
      .rd_dat_o (rd_dat_o)
   );

endmodule

`default_nettype wire

/* tb_prefetch.sv */
`default_nettype none

module tb_prefetch;

   import prefetch_pkg::*;

   // ----------------------------------------
   // Configuration.
   // ----------------------------------------

   localparam int COUNT  = 47;
   localparam int BSIZE  = 5;
   localparam int BBITS  = 3;
   localparam int PERIOD = 20;
   localparam logic [31:0] SEED = 32'h6f889f7d;

   // Words per prefetch.
   localparam int N = COUNT + 1;
   // Blocks touched, and the source span that covers them.
   localparam int BLOCKS     = COUNT / (BSIZE + 1) + 1;
   localparam int LOAD_WORDS = BLOCKS * (1 << BBITS);
   // Edge of done_o, counted from the begin_i sample at edge 0.
   localparam int DONE_EDGE    = COUNT + 4;
   localparam int DONE_TIMEOUT = 2 * N + 20;
   // Run length bound: load, prefetch and read-back per test.
   localparam int N_TESTS     = 5;
   localparam int TEST_CYCLES = LOAD_WORDS + 2 * N + 20;
   localparam int WD_CYCLES   = N_TESTS * TEST_CYCLES + 10;

   logic              clk;
   logic              rst;
   logic              begin_req;
   logic              load_we;
   logic [ADR_W-1:0]  load_adr;
   logic [DATA_W-1:0] load_dat;
   logic [ADR_W-1:0]  rd_adr;
   logic [DATA_W-1:0] rd_dat;
   logic              busy;
   logic              done;

   // Copy of what the host put into the source bank.
   logic [DATA_W-1:0] src_model [LOAD_WORDS];

   prefetch_top #(
      .COUNT (COUNT),
      .BSIZE (BSIZE),
      .BBITS (BBITS)
   ) uut (
      .clk_i      (clk),
      .rst_i      (rst),
      .begin_i    (begin_req),
      .load_we_i  (load_we),
      .load_adr_i (load_adr),
      .load_dat_i (load_dat),
      .rd_adr_i   (rd_adr),
      .rd_dat_o   (rd_dat),
      .busy_o     (busy),
      .done_o     (done)
   );

   // ----------------------------------------
   // Clock and watchdog.
   // ----------------------------------------

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

   initial begin
      #(WD_CYCLES * PERIOD);
      $display("Watchdog expired, the tests did not finish in time.");
      $display("Simulation failed");
      $fatal(1);
   end

   // ----------------------------------------
   // Helpers.
   // ----------------------------------------

   task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   // Source address of transfer index idx.
   // Each block holds BSIZE+1 valid words on a stride of 2^BBITS.
   function automatic int expected_addr(input int idx);
      return (idx / (BSIZE + 1)) * (1 << BBITS) + idx % (BSIZE + 1);
   endfunction

   // Fill the whole source span with fresh random words.
   task automatic load_source();
      for (int a = 0; a < LOAD_WORDS; a++) begin
         src_model[a] = $urandom;
         load_we  = 1'b1;
         load_adr = ADR_W'(a);
         load_dat = src_model[a];
         @(negedge clk);
      end
      load_we = 1'b0;
   endtask

   // Pulse begin_i and follow the run edge by edge.
   // Values seen at falling edge m are the ones sampled at rising edge m.
   task automatic run_prefetch(input bit mid_begin);
      int edge_n;
      bit seen_done;
      edge_n    = 0;
      seen_done = 1'b0;
      begin_req = 1'b1;
      while (!seen_done && edge_n < DONE_TIMEOUT) begin
         @(negedge clk);
         edge_n++;
         // Optional second begin halfway through, must be ignored.
         begin_req = mid_begin && (edge_n == N / 2);
         check_value("busy_o", busy, (edge_n <= N + 2));
         if (done) begin
            seen_done = 1'b1;
         end
      end
      if (!seen_done) begin
         $display("done_o never rose after begin_i within %0d cycles.", DONE_TIMEOUT);
         $display("Simulation failed");
         $fatal(1);
      end
      check_value("done_o edge", edge_n, DONE_EDGE);
      // Done is a single-cycle pulse.
      @(negedge clk);
      check_value("done_o", done, 1'b0);
      check_value("busy_o", busy, 1'b0);
   endtask

   // Destination word i must hold the source word at its block address.
   task automatic read_back_check();
      rd_adr = '0;
      for (int i = 0; i <= COUNT; i++) begin
         @(negedge clk);
         check_value($sformatf("rd_dat_o[%0d]", i), rd_dat, src_model[expected_addr(i)]);
         rd_adr = ADR_W'(i + 1);
      end
   endtask

   // ----------------------------------------
   // Tests.
   // ----------------------------------------

   task automatic test_reset_idle();
      repeat (10) begin
         check_value("busy_o", busy, 1'b0);
         check_value("done_o", done, 1'b0);
         @(negedge clk);
      end
   endtask

   task automatic test_data_transfer();
      load_source();
      run_prefetch(1'b0);
      read_back_check();
   endtask

   task automatic test_done_timing();
      run_prefetch(1'b0);
      // Nothing moves once the run is over.
      repeat (5) begin
         @(negedge clk);
         check_value("busy_o", busy, 1'b0);
         check_value("done_o", done, 1'b0);
      end
   endtask

   task automatic test_ignored_begin();
      // Fresh data, so the read-back can only match this run's writes.
      load_source();
      run_prefetch(1'b1);
      read_back_check();
   endtask

   task automatic test_reload();
      load_source();
      run_prefetch(1'b0);
      read_back_check();
   endtask

   // ----------------------------------------
   // Main sequence.
   // ----------------------------------------

   initial begin
      void'($urandom(SEED));
      rst       = 1'b1;
      begin_req = 1'b0;
      load_we   = 1'b0;
      load_adr  = '0;
      load_dat  = '0;
      rd_adr    = '0;
      repeat (5) @(negedge clk);
      rst = 1'b0;

      test_reset_idle();
      test_data_transfer();
      test_done_timing();
      test_ignored_begin();
      test_reload();

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
prefetch_pkg.sv
src_bank.sv
fetch_stage.sv
store_stage.sv
dst_bank.sv
prefetch_top.sv
tb_prefetch.sv

/* Makefile */
# Verilator build and run for the block prefetch engine.

VERILATOR ?= verilator
TOP       ?= tb_prefetch
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Status comes from the search for the pass line, not from the binary.
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
